//--- hw/adc_capture_config.svh
/*
 * ADC capture configuration
 * widths, capture depth, frame pattern and timing constants
 */
`ifndef ADC_CAPTURE_CONFIG_SVH
`define ADC_CAPTURE_CONFIG_SVH

// one deserializer word per lane per clock
`define LANE_BITS 8
`define SLIP_BITS 3
`define SAMPLE_BITS 16

// capture depth as log2
`define RAM_ADDR_BITS 10

// frame lane word once aligned
`define FRAME_PATTERN 8'hF0

// clocks to wait after each bitslip step
`define SETTLE_CYCLES 4
`define SYNC_STAGES 3

`endif

//--- hw/adc_capture_pkg.sv
/*
 * ADC capture types
 * lane words, channel samples, capture words and alignment status
 */
`include "adc_capture_config.svh"

package adc_capture_pkg;

	typedef logic [`LANE_BITS-1:0] lane_word_t;
	typedef logic [`SLIP_BITS-1:0] slip_t;

	// both lanes of one channel
	typedef struct packed {
		lane_word_t lane_a;
		lane_word_t lane_b;
	} lane_pair_t;

	typedef logic [`SAMPLE_BITS-1:0] adc_sample_t;

	// channel 0 sits in the upper half
	typedef struct packed {
		adc_sample_t ch0;
		adc_sample_t ch1;
	} capture_word_t;

	typedef logic [`RAM_ADDR_BITS-1:0] ram_addr_t;

	typedef struct packed {
		logic  frame_valid;
		slip_t bitslip_count;
	} align_status_t;

endpackage

//--- hw/bitslip_shifter.sv
/*
 * Bitslip shifter
 * picks an 8-bit window out of the previous and current lane words,
 * a cycle-by-cycle model of the deserializer bitslip
 */
`timescale 1ns/1ps

module bitslip_shifter (
	input  logic                      data_clk_div,
	input  logic                      rst_n,
	input  adc_capture_pkg::lane_word_t word_in,
	input  adc_capture_pkg::slip_t      bitslip_count,
	output adc_capture_pkg::lane_word_t word_out
);

	localparam int LW = $bits(adc_capture_pkg::lane_word_t);

	adc_capture_pkg::lane_word_t prev_word;
	logic [2*LW-1:0] window;

	// previous word low, current word high
	always_comb begin
		window = {word_in, prev_word};
	end

	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			prev_word <= '0;
			word_out  <= '0;
		end else begin
			prev_word <= word_in;
			word_out  <= window[bitslip_count +: LW];
		end
	end

endmodule

//--- hw/frame_aligner.sv
/*
 * Frame aligner
 * steps the bitslip offset until the frame lane shows the frame pattern,
 * then holds the offset and flags frame_valid while matches continue
 */
`timescale 1ns/1ps

`include "adc_capture_config.svh"

module frame_aligner (
	input  logic                         data_clk_div,
	input  logic                         rst_n,
	input  logic                         enable_adc,
	input  adc_capture_pkg::lane_word_t    frame_word,
	output adc_capture_pkg::align_status_t align_status
);

	localparam int SETTLE_W = $clog2(`SETTLE_CYCLES + 1);

	adc_capture_pkg::slip_t      slip_q;
	adc_capture_pkg::lane_word_t shifted_word;
	logic                        valid_q;
	logic [SETTLE_W-1:0]         settle_cnt;

	bitslip_shifter u_frame_shift (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.word_in      (frame_word),
		.bitslip_count(slip_q),
		.word_out     (shifted_word)
	);

	always_ff @(posedge data_clk_div) begin
		if (!rst_n || !enable_adc) begin
			slip_q     <= '0;
			valid_q    <= 1'b0;
			settle_cnt <= SETTLE_W'(`SETTLE_CYCLES);
		end else if (settle_cnt != '0) begin
			// shifter output still reflects an older offset
			settle_cnt <= settle_cnt - 1'b1;
		end else if (shifted_word == `FRAME_PATTERN) begin
			valid_q <= 1'b1;
		end else begin
			// lost or never found, try the next offset
			valid_q    <= 1'b0;
			slip_q     <= slip_q + 1'b1;
			settle_cnt <= SETTLE_W'(`SETTLE_CYCLES);
		end
	end

	assign align_status = '{frame_valid: valid_q, bitslip_count: slip_q};

	// the data PHYs rely on a steady offset once locked
	a_slip_stable_when_valid: assert property (
		@(posedge data_clk_div) disable iff (!rst_n)
		align_status.frame_valid |-> $stable(align_status.bitslip_count)
	);

endmodule

//--- hw/adc_data_phy.sv
/*
 * ADC data PHY
 * aligns both lanes of one channel with the shared bitslip offset
 * and bit-interleaves them into one 16-bit sample
 */
`timescale 1ns/1ps

module adc_data_phy (
	input  logic                        data_clk_div,
	input  logic                        rst_n,
	input  adc_capture_pkg::lane_pair_t  lanes,
	input  adc_capture_pkg::slip_t       bitslip_count,
	output adc_capture_pkg::adc_sample_t sample
);

	localparam int LW = $bits(adc_capture_pkg::lane_word_t);

	adc_capture_pkg::lane_word_t  lane_a_al;
	adc_capture_pkg::lane_word_t  lane_b_al;
	adc_capture_pkg::adc_sample_t interleaved;

	bitslip_shifter u_shift_a (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.word_in      (lanes.lane_a),
		.bitslip_count(bitslip_count),
		.word_out     (lane_a_al)
	);

	bitslip_shifter u_shift_b (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.word_in      (lanes.lane_b),
		.bitslip_count(bitslip_count),
		.word_out     (lane_b_al)
	);

	// lane a on even bits, lane b on odd bits
	always_comb begin
		for (int i = 0; i < LW; i++) begin
			interleaved[2*i]   = lane_a_al[i];
			interleaved[2*i+1] = lane_b_al[i];
		end
	end

	always_ff @(posedge data_clk_div) begin
		sample <= interleaved;
	end

endmodule

//--- hw/capture_control.sv
/*
 * Capture controller
 * synchronizes enable_bram, starts a fill of the capture RAM on its
 * rising edge and stops after the last address until it falls again
 */
`timescale 1ns/1ps

`include "adc_capture_config.svh"

module capture_control (
	input  logic                      data_clk_div,
	input  logic                      rst_n,
	input  logic                      enable_bram,
	output adc_capture_pkg::ram_addr_t wr_addr,
	output logic                      wr_en,
	output logic                      capture_done
);

	logic [`SYNC_STAGES-1:0] en_sync;
	logic                    en_d;
	logic                    en_rise;
	logic                    en_fall;

	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			en_sync <= '0;
			en_d    <= 1'b0;
		end else begin
			en_sync <= {en_sync[`SYNC_STAGES-2:0], enable_bram};
			en_d    <= en_sync[`SYNC_STAGES-1];
		end
	end

	assign en_rise = en_sync[`SYNC_STAGES-1] & ~en_d;
	assign en_fall = ~en_sync[`SYNC_STAGES-1] & en_d;

	always_ff @(posedge data_clk_div) begin
		if (!rst_n || en_fall) begin
			wr_en        <= 1'b0;
			capture_done <= 1'b0;
			wr_addr      <= '0;
		end else if (en_rise) begin
			wr_en        <= 1'b1;
			capture_done <= 1'b0;
			wr_addr      <= '0;
		end else if (wr_en) begin
			if (wr_addr == '1) begin
				// last entry written, hold until enable_bram drops
				wr_en        <= 1'b0;
				capture_done <= 1'b1;
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	a_no_write_when_done: assert property (
		@(posedge data_clk_div) disable iff (!rst_n)
		!(wr_en && capture_done)
	);

endmodule

//--- hw/capture_ram.sv
/*
 * Capture RAM
 * 1024 x 32 single-clock storage, one write port and a registered read
 */
`timescale 1ns/1ps

module capture_ram (
	input  logic                          data_clk_div,
	input  logic                          wr_en,
	input  adc_capture_pkg::ram_addr_t    wr_addr,
	input  adc_capture_pkg::capture_word_t wr_data,
	input  adc_capture_pkg::ram_addr_t    rd_addr,
	output adc_capture_pkg::capture_word_t rd_data
);

	localparam int DEPTH = 1 << $bits(adc_capture_pkg::ram_addr_t);

	adc_capture_pkg::capture_word_t mem [DEPTH];

	always_ff @(posedge data_clk_div) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read so it maps onto block RAM
	always_ff @(posedge data_clk_div) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- hw/adc_capture_top.sv
/*
 * ADC capture top level
 * frame aligner, two channel PHYs, capture controller and capture RAM
 */
`timescale 1ns/1ps

module adc_capture_top (
	input  logic                          data_clk_div,
	input  logic                          rst_n,
	input  logic                          enable_adc,
	input  logic                          enable_bram,
	input  adc_capture_pkg::lane_word_t    frame_word,
	input  adc_capture_pkg::lane_pair_t    ch0_lanes,
	input  adc_capture_pkg::lane_pair_t    ch1_lanes,
	input  adc_capture_pkg::ram_addr_t     rd_addr,
	output adc_capture_pkg::align_status_t align_status,
	output logic                          capture_done,
	output adc_capture_pkg::capture_word_t rd_data
);

	adc_capture_pkg::adc_sample_t   ch0_sample;
	adc_capture_pkg::adc_sample_t   ch1_sample;
	adc_capture_pkg::capture_word_t wr_data;
	adc_capture_pkg::ram_addr_t     wr_addr;
	logic                           wr_en;

	frame_aligner u_aligner (
		.data_clk_div(data_clk_div),
		.rst_n       (rst_n),
		.enable_adc  (enable_adc),
		.frame_word  (frame_word),
		.align_status(align_status)
	);

	// both channels follow the offset found on the frame lane
	adc_data_phy u_phy_ch0 (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.lanes        (ch0_lanes),
		.bitslip_count(align_status.bitslip_count),
		.sample       (ch0_sample)
	);

	adc_data_phy u_phy_ch1 (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.lanes        (ch1_lanes),
		.bitslip_count(align_status.bitslip_count),
		.sample       (ch1_sample)
	);

	assign wr_data = '{ch0: ch0_sample, ch1: ch1_sample};

	capture_control u_ctrl (
		.data_clk_div(data_clk_div),
		.rst_n       (rst_n),
		.enable_bram (enable_bram),
		.wr_addr     (wr_addr),
		.wr_en       (wr_en),
		.capture_done(capture_done)
	);

	capture_ram u_ram (
		.data_clk_div(data_clk_div),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data)
	);

endmodule

//--- tests/tb_adc_capture.sv
/*
 * ADC capture testbench
 * drives skewed frame and data lanes, checks alignment, capture fills
 * and the interleaved samples read back from the capture RAM
 */
`timescale 1ns/1ps

`include "adc_capture_config.svh"

module tb_adc_capture;

	localparam int DEPTH = 1 << `RAM_ADDR_BITS;

	logic                           data_clk_div;
	logic                           rst_n;
	logic                           enable_adc;
	logic                           enable_bram;
	adc_capture_pkg::lane_word_t    frame_word;
	adc_capture_pkg::lane_pair_t    ch0_lanes;
	adc_capture_pkg::lane_pair_t    ch1_lanes;
	adc_capture_pkg::ram_addr_t     rd_addr;
	adc_capture_pkg::align_status_t align_status;
	logic                           capture_done;
	adc_capture_pkg::capture_word_t rd_data;

	// hidden lane skew and the offset that should undo it
	logic [2:0]                     d;
	adc_capture_pkg::slip_t         exp_slip;

	// true bytes per data lane: ch0 a, ch0 b, ch1 a, ch1 b
	adc_capture_pkg::lane_word_t    cur_b [4];
	adc_capture_pkg::lane_word_t    nxt_b [4];

	adc_capture_pkg::capture_word_t exp_q [$];
	adc_capture_pkg::capture_word_t rd_words [DEPTH];

	int checks;
	int errors;
	int timeouts;
	int first_start;
	int second_start;

	adc_capture_top u_dut (
		.data_clk_div(data_clk_div),
		.rst_n       (rst_n),
		.enable_adc  (enable_adc),
		.enable_bram (enable_bram),
		.frame_word  (frame_word),
		.ch0_lanes   (ch0_lanes),
		.ch1_lanes   (ch1_lanes),
		.rd_addr     (rd_addr),
		.align_status(align_status),
		.capture_done(capture_done),
		.rd_data     (rd_data)
	);

	always #10 data_clk_div = ~data_clk_div;

	// offset k at which {cur, prev} starting at bit k shows the frame pattern
	function automatic adc_capture_pkg::slip_t ref_offset(
		input adc_capture_pkg::lane_word_t prev,
		input adc_capture_pkg::lane_word_t cur
	);
		logic [15:0] win;
		win = {cur, prev};
		for (int k = 0; k < 8; k++) begin
			if (win[k +: 8] == `FRAME_PATTERN) begin
				return 3'(k);
			end
		end
		return '0;
	endfunction

	// lane a on even sample bits, lane b on odd
	function automatic adc_capture_pkg::adc_sample_t interleave(
		input adc_capture_pkg::lane_word_t a,
		input adc_capture_pkg::lane_word_t b
	);
		adc_capture_pkg::adc_sample_t s;
		for (int i = 0; i < 8; i++) begin
			s[2*i]   = a[i];
			s[2*i+1] = b[i];
		end
		return s;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic end_run();
		$display("checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	endtask

	task automatic set_offset(input logic [2:0] new_d);
		logic [15:0]                 pair;
		adc_capture_pkg::lane_word_t fw;
		pair     = {`FRAME_PATTERN, `FRAME_PATTERN};
		fw       = pair[new_d +: 8];
		d        = new_d;
		exp_slip = ref_offset(fw, fw);
	endtask

	task automatic wait_frame_valid(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge data_clk_div);
		while (align_status.frame_valid !== level && n < limit) begin
			@(negedge data_clk_div);
			n++;
		end
		if (align_status.frame_valid !== level) begin
			timeouts++;
			$display("timeout: frame_valid did not go to %0b in %0d cycles", level, limit);
		end
	endtask

	task automatic wait_capture_done(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge data_clk_div);
		while (capture_done !== level && n < limit) begin
			@(negedge data_clk_div);
			n++;
		end
		if (capture_done !== level) begin
			timeouts++;
			$display("timeout: capture_done did not go to %0b in %0d cycles", level, limit);
		end
	endtask

	task automatic read_capture();
		for (int a = 0; a < DEPTH; a++) begin
			@(posedge data_clk_div);
			rd_addr <= adc_capture_pkg::ram_addr_t'(a);
			@(posedge data_clk_div);
			@(negedge data_clk_div);
			rd_words[a] = rd_data;
		end
	endtask

	// locate the captured run in the stream of expected words
	task automatic find_run(output int start);
		start = -1;
		for (int i = 0; i + 1 < exp_q.size(); i++) begin
			if (start < 0 && exp_q[i] == rd_words[0] && exp_q[i+1] == rd_words[1]) begin
				start = i;
			end
		end
		if (start < 0) begin
			errors++;
			$display("captured words do not appear in the generated sample stream");
		end
	endtask

	task automatic check_run(input int start);
		if (start >= 0 && start + DEPTH <= exp_q.size()) begin
			for (int i = 0; i < DEPTH; i++) begin
				check($sformatf("rd_data[%0d]", i), exp_q[start+i], rd_words[i]);
			end
		end else if (start >= 0) begin
			errors++;
			$display("captured run runs past the end of the generated sample stream");
		end
	endtask

	// idle, lock, two fills, then a relock at a new skew
	task automatic run_checks();
		// idle after reset
		@(negedge data_clk_div);
		check("frame_valid", 32'(1'b0), 32'(align_status.frame_valid));
		check("bitslip_count", 32'(3'd0), 32'(align_status.bitslip_count));
		check("capture_done", 32'(1'b0), 32'(capture_done));

		// alignment
		@(posedge data_clk_div);
		enable_adc <= 1'b1;
		wait_frame_valid(1'b1, 200);
		if (timeouts != 0) begin
			return;
		end
		check("bitslip_count", 32'(exp_slip), 32'(align_status.bitslip_count));

		// first fill
		@(posedge data_clk_div);
		enable_bram <= 1'b1;
		wait_capture_done(1'b1, 1200);
		if (timeouts != 0) begin
			return;
		end
		read_capture();
		find_run(first_start);
		check_run(first_start);

		// rearm and fill again
		@(posedge data_clk_div);
		enable_bram <= 1'b0;
		wait_capture_done(1'b0, 20);
		if (timeouts != 0) begin
			return;
		end
		@(posedge data_clk_div);
		enable_bram <= 1'b1;
		wait_capture_done(1'b1, 1200);
		if (timeouts != 0) begin
			return;
		end
		read_capture();
		find_run(second_start);
		if (second_start >= 0 && second_start <= first_start) begin
			errors++;
			$display("second capture does not start after the first one in the stream");
		end
		check_run(second_start);

		// drop the ADC enable, change the skew, lock again
		@(posedge data_clk_div);
		enable_adc <= 1'b0;
		wait_frame_valid(1'b0, 20);
		if (timeouts != 0) begin
			return;
		end
		@(negedge data_clk_div);
		check("frame_valid", 32'(1'b0), 32'(align_status.frame_valid));
		check("bitslip_count", 32'(3'd0), 32'(align_status.bitslip_count));
		set_offset(3'(d + 3'd1 + 3'($urandom_range(0, 6))));
		repeat (4) @(posedge data_clk_div);
		enable_adc <= 1'b1;
		wait_frame_valid(1'b1, 200);
		if (timeouts != 0) begin
			return;
		end
		check("bitslip_count", 32'(exp_slip), 32'(align_status.bitslip_count));
	endtask

	// lane word generator, every stream cut into words skewed by d
	always @(posedge data_clk_div) begin
		logic [15:0]                    pair;
		adc_capture_pkg::lane_word_t    lane_words [4];
		adc_capture_pkg::capture_word_t exp_word;
		pair = {`FRAME_PATTERN, `FRAME_PATTERN};
		frame_word <= pair[d +: 8];
		for (int l = 0; l < 4; l++) begin
			pair          = {nxt_b[l], cur_b[l]};
			lane_words[l] = pair[d +: 8];
		end
		ch0_lanes <= '{lane_a: lane_words[0], lane_b: lane_words[1]};
		ch1_lanes <= '{lane_a: lane_words[2], lane_b: lane_words[3]};
		exp_word.ch0 = interleave(cur_b[0], cur_b[1]);
		exp_word.ch1 = interleave(cur_b[2], cur_b[3]);
		exp_q.push_back(exp_word);
		for (int l = 0; l < 4; l++) begin
			cur_b[l] = nxt_b[l];
			nxt_b[l] = 8'($urandom);
		end
	end

	// locked offset must always match the reference
	always @(negedge data_clk_div) begin
		if (rst_n && enable_adc && align_status.frame_valid) begin
			check("bitslip_count", 32'(exp_slip), 32'(align_status.bitslip_count));
		end
	end

	initial begin
		void'($urandom(32));
		checks       = 0;
		errors       = 0;
		timeouts     = 0;
		data_clk_div = 1'b0;
		rst_n       <= 1'b0;
		enable_adc  <= 1'b0;
		enable_bram <= 1'b0;
		frame_word  <= '0;
		ch0_lanes   <= '0;
		ch1_lanes   <= '0;
		rd_addr     <= '0;
		for (int l = 0; l < 4; l++) begin
			cur_b[l] = 8'($urandom);
			nxt_b[l] = 8'($urandom);
		end
		set_offset(3'($urandom_range(0, 7)));
		repeat (8) @(posedge data_clk_div);
		rst_n <= 1'b1;
		repeat (4) @(posedge data_clk_div);
		run_checks();
		end_run();
	end

endmodule

//--- tb.f
+incdir+hw
hw/adc_capture_pkg.sv
hw/bitslip_shifter.sv
hw/frame_aligner.sv
hw/adc_data_phy.sv
hw/capture_control.sv
hw/capture_ram.sv
hw/adc_capture_top.sv
tests/tb_adc_capture.sv

//--- run_sim.sh
#!/bin/sh
# build the ADC capture testbench with Verilator and run it
verilator --binary --timing --assert -j 0 --top-module tb_adc_capture \
	-f tb.f -Mdir obj_dir -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -F 'All tests passed!' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
